// ==== Bender.yml ====
package:
  name: gen

sources:
  - include_dirs:
      - include
    files:
      - source/gen_pkg.sv
      - source/gen_regs.sv
      - source/gen_phase.sv
      - source/gen_burst.sv
      - source/gen_out.sv
      - source/gen.sv
  - target: test
    include_dirs:
      - include
    files:
      - verification/gen_assert.sv
      - verification/gen_tb.sv

// ==== gen.f ====
+incdir+include
source/gen_pkg.sv
source/gen_regs.sv
source/gen_phase.sv
source/gen_burst.sv
source/gen_out.sv
source/gen.sv
verification/gen_assert.sv
verification/gen_tb.sv

// ==== include/gen_defs.svh ====
// generator channel widths, table depth, event and credit counts
// register map offsets
`ifndef GEN_DEFS_SVH
`define GEN_DEFS_SVH

// signed sample width
`define GEN_DW 16
// pointer integer and fraction bits
`define GEN_CWM 8
`define GEN_CWF 8
`define GEN_CW (`GEN_CWM + `GEN_CWF)
`define GEN_TBL_DEPTH (1 << `GEN_CWM)
// external event lines
`define GEN_EW 4
// burst counters
`define GEN_BLW 16
// downstream credits after reset
`define GEN_CREDITS 4

////////////////////
// register map
////////////////////
`define GEN_BAW 7
`define GEN_A_CTL     7'h00
`define GEN_A_IRQ_ENA 7'h08
`define GEN_A_IRQ_STS 7'h0c
`define GEN_A_MSK_CLR 7'h10
`define GEN_A_MSK_STR 7'h14
`define GEN_A_MSK_STP 7'h18
`define GEN_A_MSK_TRG 7'h1c
`define GEN_A_SIZ     7'h20
`define GEN_A_OFF     7'h24
`define GEN_A_STE     7'h28
`define GEN_A_BMODE   7'h30
`define GEN_A_BDL     7'h34
`define GEN_A_BLN     7'h38
`define GEN_A_BNM     7'h3c
`define GEN_A_BCNT    7'h40
`define GEN_A_MUL     7'h50
`define GEN_A_SUM     7'h54
`define GEN_A_ENA     7'h58

`endif

// ==== source/gen.sv ====
// generator channel top level
// registers, phase path, burst path and output stage
`timescale 1ns/1ps
`default_nettype none

`include "gen_defs.svh"

module gen (
  input  logic                    bus,
  input  logic                    ctl_rst,
  input  gen_pkg::gen_bus_req_t   reg_req,
  output gen_pkg::gen_bus_rsp_t   reg_rsp,
  input  gen_pkg::gen_tbl_wr_t    tbl_wr,
  input  logic [`GEN_EW-1:0]      evn_ext,
  output gen_pkg::gen_stream_t    sto,
  input  logic                    sto_credit,
  output gen_pkg::gen_evn_t       evn,
  output logic                    irq
);

  gen_pkg::gen_cfg_t   cfg;
  gen_pkg::gen_ctl_t   ctl;
  gen_pkg::gen_smp_t   smp;
  gen_pkg::gen_gate_t  gate;
  // single advance from the output stage drives both paths
  logic                adv;
  logic                run;
  logic                load;
  logic                sts_arm;
  logic [`GEN_BLW-1:0] sts_bcnt;

  ////////////////////
  // registers
  ////////////////////
  gen_regs u_regs (
    .bus      (bus),
    .ctl_rst  (ctl_rst),
    .reg_req  (reg_req),
    .reg_rsp  (reg_rsp),
    .evn_ext  (evn_ext),
    .lst      (evn.lst),
    .sts_run  (run),
    .sts_arm  (sts_arm),
    .sts_bcnt (sts_bcnt),
    .cfg      (cfg),
    .ctl      (ctl),
    .irq      (irq)
  );

  ////////////////////
  // datapath
  ////////////////////
  gen_phase u_phase (
    .bus     (bus),
    .ctl_rst (ctl_rst),
    .tbl_wr  (tbl_wr),
    .cfg     (cfg),
    .load    (load),
    .adv     (adv),
    .smp     (smp)
  );

  gen_burst u_burst (
    .bus      (bus),
    .ctl_rst  (ctl_rst),
    .cfg      (cfg),
    .ctl      (ctl),
    .adv      (adv),
    .run      (run),
    .load     (load),
    .gate     (gate),
    .sts_arm  (sts_arm),
    .sts_bcnt (sts_bcnt)
  );

  gen_out u_out (
    .bus        (bus),
    .ctl_rst    (ctl_rst),
    .cfg        (cfg),
    .run        (run),
    .smp        (smp),
    .gate       (gate),
    .sto_credit (sto_credit),
    .adv        (adv),
    .sto        (sto),
    .evn        (evn)
  );

endmodule

`default_nettype wire

// ==== source/gen_burst.sv ====
// burst sequencer of the generator channel
// state machine with data, idle and repetition counters, gate and reload
`timescale 1ns/1ps
`default_nettype none

`include "gen_defs.svh"

module gen_burst (
  input  logic                    bus,
  input  logic                    ctl_rst,
  input  gen_pkg::gen_cfg_t       cfg,
  input  gen_pkg::gen_ctl_t       ctl,
  input  logic                    adv,
  output logic                    run,
  output logic                    load,
  output gen_pkg::gen_gate_t      gate,
  output logic                    sts_arm,
  output logic [`GEN_BLW-1:0]     sts_bcnt
);

  gen_pkg::gen_state_e state, state_n;

  // data and idle counters within a burst
  logic [`GEN_BLW-1:0] cnt_dat, cnt_dat_n;
  logic [`GEN_BLW-1:0] cnt_idl, cnt_idl_n;
  // completed bursts
  logic [`GEN_BLW-1:0] bcnt, bcnt_n;
  logic                go;
  logic                fin;

  assign run      = (state == gen_pkg::DATA) || (state == gen_pkg::PAUSE);
  assign sts_arm  = (state == gen_pkg::ARMED);
  assign sts_bcnt = bcnt;

  // trigger while armed, or start and trigger together
  assign go = ((state == gen_pkg::ARMED) && ctl.trg) ||
              ((state == gen_pkg::IDLE) && ctl.str && ctl.trg);

  ////////////////////
  // next state
  ////////////////////
  always_comb begin
    state_n   = state;
    cnt_dat_n = cnt_dat;
    cnt_idl_n = cnt_idl;
    bcnt_n    = bcnt;
    load      = 1'b0;
    fin       = 1'b0;
    if (ctl.clr) begin
      state_n = gen_pkg::IDLE;
      bcnt_n  = '0;
    end else if (ctl.stp) begin
      state_n = gen_pkg::IDLE;
    end else if (go) begin
      state_n   = gen_pkg::DATA;
      load      = 1'b1;
      cnt_dat_n = '0;
      bcnt_n    = '0;
    end else begin
      case (state)
        gen_pkg::IDLE: begin
          if (ctl.str) begin
            state_n = gen_pkg::ARMED;
          end
        end
        // continuous mode stays here until stop
        gen_pkg::DATA: begin
          if (adv && cfg.ben) begin
            if (cnt_dat == cfg.bdl - 1'b1) begin
              cnt_dat_n = '0;
              cnt_idl_n = '0;
              bcnt_n    = bcnt + 1'b1;
              if (!cfg.inf && (bcnt_n == cfg.bnm)) begin
                state_n = gen_pkg::IDLE;
                fin     = 1'b1;
              end else if (cfg.bln == '0) begin
                load = 1'b1;
              end else begin
                state_n = gen_pkg::PAUSE;
              end
            end else begin
              cnt_dat_n = cnt_dat + 1'b1;
            end
          end
        end
        gen_pkg::PAUSE: begin
          if (adv) begin
            if (cnt_idl == cfg.bln - 1'b1) begin
              state_n = gen_pkg::DATA;
              load    = 1'b1;
            end else begin
              cnt_idl_n = cnt_idl + 1'b1;
            end
          end
        end
        default: ;
      endcase
    end
  end

  ////////////////////
  // state and gate
  ////////////////////
  // gate delayed once to line up with the table read
  always_ff @(posedge bus) begin
    if (ctl_rst) begin
      state   <= gen_pkg::IDLE;
      cnt_dat <= '0;
      cnt_idl <= '0;
      bcnt    <= '0;
      gate    <= '0;
    end else begin
      state       <= state_n;
      cnt_dat     <= cnt_dat_n;
      cnt_idl     <= cnt_idl_n;
      bcnt        <= bcnt_n;
      gate.vld    <= adv;
      gate.dat_en <= (state == gen_pkg::DATA);
      gate.lst    <= fin;
    end
  end

endmodule

`default_nettype wire

// ==== source/gen_out.sv ====
// output stage of the generator channel
// credit counter, advance, gain and offset with saturation, stream and events
`timescale 1ns/1ps
`default_nettype none

`include "gen_defs.svh"

module gen_out (
  input  logic                   bus,
  input  logic                   ctl_rst,
  input  gen_pkg::gen_cfg_t      cfg,
  input  logic                   run,
  input  gen_pkg::gen_smp_t      smp,
  input  gen_pkg::gen_gate_t     gate,
  input  logic                   sto_credit,
  output logic                   adv,
  output gen_pkg::gen_stream_t   sto,
  output gen_pkg::gen_evn_t      evn
);

  localparam int DW  = `GEN_DW;
  localparam int CRW = $clog2(`GEN_CREDITS + 1);
  localparam logic signed [2*DW:0] SAT_MAX = (2**(DW-1)) - 1;
  localparam logic signed [2*DW:0] SAT_MIN = -(2**(DW-1));

  logic [CRW-1:0]          crd;
  logic signed [2*DW-1:0]  mul_full;
  logic signed [2*DW-1:0]  mul_sh;
  logic signed [2*DW:0]    add_full;
  logic signed [DW-1:0]    sat;
  logic signed [DW-1:0]    dat_w;

  ////////////////////
  // credits
  ////////////////////
  // one advance per free credit
  assign adv = run && (crd != '0);

  always_ff @(posedge bus) begin
    if (ctl_rst) begin
      crd <= CRW'(`GEN_CREDITS);
    end else if (adv && !sto_credit) begin
      crd <= crd - 1'b1;
    end else if (!adv && sto_credit) begin
      crd <= crd + 1'b1;
    end
  end

  ////////////////////
  // transform
  ////////////////////
  always_comb begin
    mul_full = smp.dat * cfg.mul;
    // drop the 14 fraction bits of the gain
    mul_sh   = mul_full >>> 14;
    add_full = mul_sh + cfg.sum;
    if (add_full > SAT_MAX) begin
      sat = SAT_MAX[DW-1:0];
    end else if (add_full < SAT_MIN) begin
      sat = SAT_MIN[DW-1:0];
    end else begin
      sat = add_full[DW-1:0];
    end
    // idle words and disabled output are zero
    dat_w = (gate.dat_en && cfg.ena) ? sat : '0;
  end

  // second stage, 2 cycles after the advance
  always_ff @(posedge bus) begin
    if (ctl_rst) begin
      sto.vld <= 1'b0;
      sto.per <= 1'b0;
      evn     <= '0;
    end else begin
      sto.vld <= gate.vld;
      sto.per <= gate.vld && gate.dat_en && smp.per;
      evn.per <= gate.vld && gate.dat_en && smp.per;
      evn.lst <= gate.vld && gate.lst;
    end
    sto.dat <= dat_w;
  end

endmodule

`default_nettype wire

// ==== source/gen_phase.sv ====
// waveform table RAM and fixed-point phase accumulator
// registered table sample with period wrap flag
`timescale 1ns/1ps
`default_nettype none

`include "gen_defs.svh"

module gen_phase (
  input  logic                  bus,
  input  logic                  ctl_rst,
  input  gen_pkg::gen_tbl_wr_t  tbl_wr,
  input  gen_pkg::gen_cfg_t     cfg,
  input  logic                  load,
  input  logic                  adv,
  output gen_pkg::gen_smp_t     smp
);

  localparam int CW  = `GEN_CW;
  localparam int CWF = `GEN_CWF;

  // table, written by the CPU only
  logic signed [`GEN_DW-1:0] tbl [`GEN_TBL_DEPTH];

  // pointer, integer part on top
  logic [CW-1:0] ptr;
  logic [CW:0]   ptr_sum;
  logic [CW:0]   ptr_dif;
  logic [CW-1:0] ptr_nxt;
  logic          wrap;

  ////////////////////
  // table RAM
  ////////////////////
  always_ff @(posedge bus) begin
    if (tbl_wr.wen) begin
      tbl[tbl_wr.addr] <= tbl_wr.wdata;
    end
  end

  ////////////////////
  // accumulator
  ////////////////////
  // one extra bit so the sum can pass the top of the range
  always_comb begin
    ptr_sum = {1'b0, ptr} + {1'b0, cfg.ste};
    ptr_dif = ptr_sum - {1'b0, cfg.siz};
    wrap    = (ptr_sum >= {1'b0, cfg.siz});
    ptr_nxt = wrap ? ptr_dif[CW-1:0] : ptr_sum[CW-1:0];
  end

  // reload beats advance
  always_ff @(posedge bus) begin
    if (ctl_rst) begin
      ptr <= '0;
    end else if (load) begin
      ptr <= cfg.off;
    end else if (adv) begin
      ptr <= ptr_nxt;
    end
  end

  // read at the pointer before the step, 1 cycle latency
  always_ff @(posedge bus) begin
    if (ctl_rst) begin
      smp.per <= 1'b0;
    end else if (adv) begin
      smp.per <= wrap;
    end
    if (adv) begin
      smp.dat <= tbl[ptr[CW-1:CWF]];
    end
  end

endmodule

`default_nettype wire

// ==== source/gen_pkg.sv ====
// shared types of the generator channel
// bus, table port, config, sample, gate, stream, events, burst state
`default_nettype none

`include "gen_defs.svh"

package gen_pkg;

  // register bus
  typedef struct packed {
    logic                wen;
    logic                ren;
    logic [`GEN_BAW-1:0] addr;
    logic [31:0]         wdata;
  } gen_bus_req_t;

  typedef struct packed {
    logic        ack;
    logic [31:0] rdata;
  } gen_bus_rsp_t;

  // waveform table write port
  typedef struct packed {
    logic                wen;
    logic [`GEN_CWM-1:0] addr;
    logic [`GEN_DW-1:0]  wdata;
  } gen_tbl_wr_t;

  // one-cycle commands
  typedef struct packed {
    logic clr;
    logic str;
    logic stp;
    logic trg;
  } gen_ctl_t;

  typedef struct packed {
    logic [`GEN_CW-1:0]         siz;
    logic [`GEN_CW-1:0]         off;
    logic [`GEN_CW-1:0]         ste;
    logic                       ben;
    logic                       inf;
    logic [`GEN_BLW-1:0]        bdl;
    logic [`GEN_BLW-1:0]        bln;
    logic [`GEN_BLW-1:0]        bnm;
    // gain has 14 fraction bits
    logic signed [`GEN_DW-1:0]  mul;
    logic signed [`GEN_DW-1:0]  sum;
    logic                       ena;
  } gen_cfg_t;

  typedef struct packed {
    logic signed [`GEN_DW-1:0] dat;
    logic                      per;
  } gen_smp_t;

  typedef struct packed {
    logic vld;
    logic dat_en;
    logic lst;
  } gen_gate_t;

  typedef struct packed {
    logic                      vld;
    logic signed [`GEN_DW-1:0] dat;
    logic                      per;
  } gen_stream_t;

  typedef struct packed {
    logic per;
    logic lst;
  } gen_evn_t;

  typedef enum logic [1:0] {IDLE, ARMED, DATA, PAUSE} gen_state_e;

endpackage

`default_nettype wire

// ==== source/gen_regs.sv ====
// register file of the generator channel
// command pulses with masked external events, irq status and output
`timescale 1ns/1ps
`default_nettype none

`include "gen_defs.svh"

module gen_regs (
  input  logic                     bus,
  input  logic                     ctl_rst,
  input  gen_pkg::gen_bus_req_t    reg_req,
  output gen_pkg::gen_bus_rsp_t    reg_rsp,
  input  logic [`GEN_EW-1:0]       evn_ext,
  input  logic                     lst,
  input  logic                     sts_run,
  input  logic                     sts_arm,
  input  logic [`GEN_BLW-1:0]      sts_bcnt,
  output gen_pkg::gen_cfg_t        cfg,
  output gen_pkg::gen_ctl_t        ctl,
  output logic                     irq
);

  // event masks
  logic [`GEN_EW-1:0] msk_clr;
  logic [`GEN_EW-1:0] msk_str;
  logic [`GEN_EW-1:0] msk_stp;
  logic [`GEN_EW-1:0] msk_trg;
  // irq bits: str, stp, trg, lst
  logic [3:0]         irq_ena;
  logic [3:0]         irq_sts;
  logic [3:0]         irq_clr;
  logic               wr_ctl;
  logic [31:0]        rd_dat;

  assign wr_ctl  = reg_req.wen && (reg_req.addr == `GEN_A_CTL);
  assign irq_clr = (reg_req.wen && (reg_req.addr == `GEN_A_IRQ_STS)) ?
                   reg_req.wdata[3:0] : 4'b0000;

  ////////////////////
  // write access
  ////////////////////
  always_ff @(posedge bus) begin
    if (ctl_rst) begin
      cfg     <= '0;
      irq_ena <= '0;
      msk_clr <= '0;
      msk_str <= '0;
      msk_stp <= '0;
      msk_trg <= '0;
    end else if (reg_req.wen) begin
      case (reg_req.addr)
        `GEN_A_IRQ_ENA: irq_ena <= reg_req.wdata[3:0];
        `GEN_A_MSK_CLR: msk_clr <= reg_req.wdata[`GEN_EW-1:0];
        `GEN_A_MSK_STR: msk_str <= reg_req.wdata[`GEN_EW-1:0];
        `GEN_A_MSK_STP: msk_stp <= reg_req.wdata[`GEN_EW-1:0];
        `GEN_A_MSK_TRG: msk_trg <= reg_req.wdata[`GEN_EW-1:0];
        `GEN_A_SIZ:     cfg.siz <= reg_req.wdata[`GEN_CW-1:0];
        `GEN_A_OFF:     cfg.off <= reg_req.wdata[`GEN_CW-1:0];
        `GEN_A_STE:     cfg.ste <= reg_req.wdata[`GEN_CW-1:0];
        `GEN_A_BMODE: begin
          cfg.ben <= reg_req.wdata[0];
          cfg.inf <= reg_req.wdata[1];
        end
        `GEN_A_BDL:     cfg.bdl <= reg_req.wdata[`GEN_BLW-1:0];
        `GEN_A_BLN:     cfg.bln <= reg_req.wdata[`GEN_BLW-1:0];
        `GEN_A_BNM:     cfg.bnm <= reg_req.wdata[`GEN_BLW-1:0];
        `GEN_A_MUL:     cfg.mul <= reg_req.wdata[`GEN_DW-1:0];
        `GEN_A_SUM:     cfg.sum <= reg_req.wdata[`GEN_DW-1:0];
        `GEN_A_ENA:     cfg.ena <= reg_req.wdata[0];
        default: ;
      endcase
    end
  end

  // software command or masked event, one cycle later
  always_ff @(posedge bus) begin
    if (ctl_rst) begin
      ctl <= '0;
    end else begin
      ctl.clr <= (wr_ctl && reg_req.wdata[0]) || (|(evn_ext & msk_clr));
      ctl.str <= (wr_ctl && reg_req.wdata[1]) || (|(evn_ext & msk_str));
      ctl.stp <= (wr_ctl && reg_req.wdata[2]) || (|(evn_ext & msk_stp));
      ctl.trg <= (wr_ctl && reg_req.wdata[3]) || (|(evn_ext & msk_trg));
    end
  end

  ////////////////////
  // read access
  ////////////////////
  always_comb begin
    case (reg_req.addr)
      `GEN_A_CTL:     rd_dat = 32'({sts_arm, sts_run});
      `GEN_A_IRQ_ENA: rd_dat = 32'(irq_ena);
      `GEN_A_IRQ_STS: rd_dat = 32'(irq_sts);
      `GEN_A_MSK_CLR: rd_dat = 32'(msk_clr);
      `GEN_A_MSK_STR: rd_dat = 32'(msk_str);
      `GEN_A_MSK_STP: rd_dat = 32'(msk_stp);
      `GEN_A_MSK_TRG: rd_dat = 32'(msk_trg);
      `GEN_A_SIZ:     rd_dat = 32'(cfg.siz);
      `GEN_A_OFF:     rd_dat = 32'(cfg.off);
      `GEN_A_STE:     rd_dat = 32'(cfg.ste);
      `GEN_A_BMODE:   rd_dat = 32'({cfg.inf, cfg.ben});
      `GEN_A_BDL:     rd_dat = 32'(cfg.bdl);
      `GEN_A_BLN:     rd_dat = 32'(cfg.bln);
      `GEN_A_BNM:     rd_dat = 32'(cfg.bnm);
      `GEN_A_BCNT:    rd_dat = 32'(sts_bcnt);
      // gain and offset read back without sign extension
      `GEN_A_MUL:     rd_dat = 32'($unsigned(cfg.mul));
      `GEN_A_SUM:     rd_dat = 32'($unsigned(cfg.sum));
      `GEN_A_ENA:     rd_dat = 32'(cfg.ena);
      default:        rd_dat = 32'd0;
    endcase
  end

  always_ff @(posedge bus) begin
    if (ctl_rst) begin
      reg_rsp.ack <= 1'b0;
    end else begin
      reg_rsp.ack <= reg_req.wen | reg_req.ren;
    end
    if (reg_req.ren) begin
      reg_rsp.rdata <= rd_dat;
    end
  end

  ////////////////////
  // interrupts
  ////////////////////
  // clear wins only for old bits, new events still set
  always_ff @(posedge bus) begin
    if (ctl_rst) begin
      irq_sts <= '0;
      irq     <= 1'b0;
    end else begin
      irq_sts <= (irq_sts & ~irq_clr) | {lst, ctl.trg, ctl.stp, ctl.str};
      irq     <= |(irq_sts & irq_ena);
    end
  end

endmodule

`default_nettype wire

// ==== verification/gen_assert.sv ====
// concurrent assertions on the generator channel
// credits, advance to stream latency, reset state, bus ack
`timescale 1ns/1ps
`default_nettype none

`include "gen_defs.svh"

module gen_assert (
  input logic                  bus,
  input logic                  ctl_rst,
  input gen_pkg::gen_bus_req_t reg_req,
  input gen_pkg::gen_bus_rsp_t reg_rsp,
  input gen_pkg::gen_stream_t  sto,
  input logic                  sto_credit,
  input logic                  adv,
  input logic                  irq
);

  // words sent and not yet credited back
  int outst;

  always_ff @(posedge bus) begin
    if (ctl_rst) begin
      outst <= 0;
    end else begin
      outst <= outst + (sto.vld ? 1 : 0) - (sto_credit ? 1 : 0);
    end
  end

  a_credit: assert property (@(posedge bus) disable iff (ctl_rst)
    outst <= `GEN_CREDITS) else $error("outstanding words above credit count");

  // stream word exactly 2 cycles after each advance, and only then
  a_vld: assert property (@(posedge bus) disable iff (ctl_rst)
    adv |-> ##2 sto.vld) else $error("advance without stream word 2 cycles later");
  a_vld_src: assert property (@(posedge bus) disable iff (ctl_rst)
    sto.vld |-> $past(adv, 2)) else $error("stream word without advance");

  a_rst: assert property (@(posedge bus)
    $past(ctl_rst) |-> (!irq && !sto.vld && !reg_rsp.ack))
    else $error("outputs active right after reset");

  a_ack: assert property (@(posedge bus) disable iff (ctl_rst)
    (reg_req.wen || reg_req.ren) |=> reg_rsp.ack) else $error("bus request without ack");

endmodule

bind gen gen_assert u_assert (
  .bus        (bus),
  .ctl_rst    (ctl_rst),
  .reg_req    (reg_req),
  .reg_rsp    (reg_rsp),
  .sto        (sto),
  .sto_credit (sto_credit),
  .adv        (adv),
  .irq        (irq)
);

`default_nettype wire

// ==== verification/gen_tb.sv ====
// testbench of the generator channel
// clock, xorshift, reference model, stimulus, comparison, credit sink, timeout
`timescale 1ns/1ps
`default_nettype none

`include "gen_defs.svh"

module gen_tb;

  localparam int N_WORDS = 40;
  // table fill plus every run with room for slow credit returns
  localparam int CYC_LIMIT = 4 * (`GEN_TBL_DEPTH + 6 * (N_WORDS + 16) * 4 + 400);
  localparam longint SMAX = (longint'(1) <<< (`GEN_DW - 1)) - 1;

  logic                  bus = 1'b0;
  logic                  ctl_rst;
  gen_pkg::gen_bus_req_t reg_req;
  gen_pkg::gen_bus_rsp_t reg_rsp;
  gen_pkg::gen_tbl_wr_t  tbl_wr;
  logic [`GEN_EW-1:0]    evn_ext;
  gen_pkg::gen_stream_t  sto;
  logic                  sto_credit;
  gen_pkg::gen_evn_t     evn;
  logic                  irq;

  logic [31:0]               rng;
  logic [31:0]               srng;
  logic [31:0]               rd;
  logic signed [`GEN_DW-1:0] tbl [`GEN_TBL_DEPTH];
  logic signed [`GEN_DW-1:0] c_mul;
  logic signed [`GEN_DW-1:0] c_sum;
  int                        c_siz;
  int                        c_off;
  int                        c_ste;
  int                        mptr;
  // expected words in order
  int                        exp_dat[$];
  bit                        exp_per[$];
  bit                        exp_lst[$];
  bit                        per_exp;
  int                        recv;
  int                        pending;
  int                        errors;
  int                        t_err;
  int                        cyc;
  bit                        hold;

  gen u_gen (
    .bus        (bus),
    .ctl_rst    (ctl_rst),
    .reg_req    (reg_req),
    .reg_rsp    (reg_rsp),
    .tbl_wr     (tbl_wr),
    .evn_ext    (evn_ext),
    .sto        (sto),
    .sto_credit (sto_credit),
    .evn        (evn),
    .irq        (irq)
  );

  always #4 bus = ~bus;

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // expected output word from gain with 14 fraction bits, offset and saturation
  function automatic logic signed [`GEN_DW-1:0] ref_word(
    input logic signed [`GEN_DW-1:0] s, input logic signed [`GEN_DW-1:0] g,
    input logic signed [`GEN_DW-1:0] o, input bit en);
    longint p;
    p = longint'(s) * longint'(g);
    p = (p >>> 14) + longint'(o);
    if (p > SMAX) begin
      p = SMAX;
    end else if (p < -SMAX - 1) begin
      p = -SMAX - 1;
    end
    if (!en) begin
      p = 0;
    end
    return `GEN_DW'(p);
  endfunction

  task automatic check_val(input string name, input int exp, input int act);
    assert (exp == act) else begin
      $display("FAIL %0t %s expected %0d got %0d", $time, name, exp, act);
      errors++;
    end
  endtask

  task automatic check_true(input bit ok, input string what);
    assert (ok) else begin
      $display("at %0t: %s", $time, what);
      errors++;
    end
  endtask

  ////////////////////
  // reference pointer model
  ////////////////////
  task automatic expect_words(input int n, input bit en, input bit lst_last);
    int nxt;
    for (int i = 0; i < n; i++) begin
      nxt = mptr + c_ste;
      exp_dat.push_back(int'(ref_word(tbl[mptr >> `GEN_CWF], c_mul, c_sum, en)));
      exp_per.push_back(nxt >= c_siz);
      exp_lst.push_back(lst_last && (i == n - 1));
      mptr = (nxt >= c_siz) ? nxt - c_siz : nxt;
    end
  endtask

  task automatic expect_zeros(input int n);
    repeat (n) begin
      exp_dat.push_back(0);
      exp_per.push_back(1'b0);
      exp_lst.push_back(1'b0);
    end
  endtask

  // three bursts of 6 data words with 3 idle words between them
  task automatic expect_bursts();
    for (int b = 0; b < 3; b++) begin
      mptr = c_off;
      expect_words(6, 1'b1, b == 2);
      if (b < 2) begin
        expect_zeros(3);
      end
    end
  endtask

  ////////////////////
  // bus access
  ////////////////////
  task automatic reg_write(input logic [`GEN_BAW-1:0] addr, input logic [31:0] data);
    @(negedge bus);
    reg_req = '{wen: 1'b1, ren: 1'b0, addr: addr, wdata: data};
    @(negedge bus);
    reg_req = '0;
    check_true(reg_rsp.ack, "no ack one cycle after a write");
  endtask

  task automatic reg_check(input logic [`GEN_BAW-1:0] addr, input logic [31:0] exp,
                           input string name);
    @(negedge bus);
    reg_req = '{wen: 1'b0, ren: 1'b1, addr: addr, wdata: 32'd0};
    @(negedge bus);
    reg_req = '0;
    check_true(reg_rsp.ack, "no ack one cycle after a read");
    rd = reg_rsp.rdata;
    check_val(name, int'(exp), int'(rd));
  endtask

  task automatic pulse_evn(input logic [`GEN_EW-1:0] bits);
    @(negedge bus);
    evn_ext = bits;
    @(negedge bus);
    evn_ext = '0;
  endtask

  task automatic start_cont(input int siz, input int off, input int ste,
    input logic signed [`GEN_DW-1:0] mul, input logic signed [`GEN_DW-1:0] sum, input bit ena);
    reg_write(`GEN_A_SIZ, 32'(siz));
    reg_write(`GEN_A_OFF, 32'(off));
    reg_write(`GEN_A_STE, 32'(ste));
    reg_write(`GEN_A_MUL, 32'(mul));
    reg_write(`GEN_A_SUM, 32'(sum));
    reg_write(`GEN_A_ENA, 32'(ena));
    c_siz = siz;
    c_off = off;
    c_ste = ste;
    c_mul = mul;
    c_sum = sum;
    mptr  = off;
  endtask

  task automatic wait_words(input int n);
    while (recv < n) begin
      @(negedge bus);
    end
  endtask

  // let the pipeline empty and drop what the model queued ahead
  task automatic drain(input bit must_empty);
    repeat (12) @(negedge bus);
    if (must_empty) begin
      check_true(exp_dat.size() == 0, "expected words never arrived");
    end
    exp_dat.delete();
    exp_per.delete();
    exp_lst.delete();
  endtask

  task automatic end_test(input int num, input string name);
    $display("test %0d %s: %s, %0d failed checks", num, name,
             (errors == t_err) ? "pass" : "failed", errors - t_err);
    t_err = errors;
  endtask

  ////////////////////
  // compare and credit sink
  ////////////////////
  always @(negedge bus) begin
    if (!ctl_rst && sto.vld) begin
      recv++;
      check_true(exp_dat.size() != 0, "stream word arrived with none expected");
      if (exp_dat.size() != 0) begin
        per_exp = exp_per.pop_front();
        check_val("sto.dat", exp_dat.pop_front(), int'(sto.dat));
        check_val("sto.per", int'(per_exp), int'(sto.per));
        check_val("evn.per", int'(per_exp), int'(evn.per));
        check_val("evn.lst", int'(exp_lst.pop_front()), int'(evn.lst));
      end
    end
  end

  // credits return after a random delay and never while held
  always @(negedge bus) begin
    sto_credit = 1'b0;
    if (!ctl_rst) begin
      if (sto.vld) begin
        pending++;
      end
      check_true(pending <= `GEN_CREDITS, "more uncredited words than credits");
      if (!hold && pending > 0) begin
        srng = xorshift(srng);
        if (srng[1:0] != 2'b00) begin
          sto_credit = 1'b1;
          pending--;
        end
      end
    end
  end

  always @(posedge bus) begin
    cyc++;
    if (cyc > CYC_LIMIT) begin
      $display("timeout: run passed %0d cycles", CYC_LIMIT);
      $display("Errors found");
      $finish;
    end
  end

  ////////////////////
  // tests
  ////////////////////
  initial begin
    reg_req    = '0;
    tbl_wr     = '0;
    evn_ext    = '0;
    sto_credit = 1'b0;
    hold       = 1'b0;
    errors     = 0;
    t_err      = 0;
    cyc        = 0;
    recv       = 0;
    pending    = 0;
    rng        = 32'h963633db;
    srng       = 32'h963633db;
    ctl_rst    = 1'b1;
    repeat (2) @(negedge bus);
    ctl_rst = 1'b0;
    // random table
    for (int a = 0; a < `GEN_TBL_DEPTH; a++) begin
      @(negedge bus);
      rng    = xorshift(rng);
      tbl[a] = rng[`GEN_DW-1:0];
      tbl_wr = '{wen: 1'b1, addr: a[`GEN_CWM-1:0], wdata: rng[`GEN_DW-1:0]};
    end
    @(negedge bus);
    tbl_wr = '0;

    // 1 register access, field widths and unmapped reads
    reg_write(`GEN_A_SIZ, 32'hffff_1234);
    reg_check(`GEN_A_SIZ, 32'h1234, "siz");
    reg_write(`GEN_A_BMODE, 32'hffff_ffff);
    reg_check(`GEN_A_BMODE, 32'h3, "bmode");
    reg_write(`GEN_A_MUL, 32'h1234_5678);
    reg_check(`GEN_A_MUL, 32'h5678, "mul");
    reg_write(`GEN_A_IRQ_ENA, 32'hff);
    reg_check(`GEN_A_IRQ_ENA, 32'hf, "irq_ena");
    reg_write(`GEN_A_MSK_TRG, 32'hffff_ffff);
    reg_check(`GEN_A_MSK_TRG, 32'hf, "msk_trg");
    reg_write(`GEN_A_BDL, 32'habcd_1234);
    reg_check(`GEN_A_BDL, 32'h1234, "bdl");
    reg_check(7'h04, 32'd0, "unmapped 0x04");
    reg_check(7'h7c, 32'd0, "unmapped 0x7c");
    reg_check(`GEN_A_CTL, 32'd0, "ctl status");
    reg_write(`GEN_A_BMODE, 32'd0);
    reg_write(`GEN_A_IRQ_ENA, 32'd0);
    reg_write(`GEN_A_MSK_TRG, 32'd0);
    end_test(1, "register access");

    // 2 continuous mode with size 200, step 3.5 and gain above 1
    rng = xorshift(rng);
    start_cont(200 << 8, 16'h0310, 16'h0380, 16'h4000 | rng[13:0], 16'sh1000, 1'b1);
    expect_words(N_WORDS + 16, 1'b1, 1'b0);
    recv = 0;
    reg_write(`GEN_A_CTL, 32'ha);
    wait_words(N_WORDS);
    reg_write(`GEN_A_CTL, 32'h4);
    drain(1'b0);
    start_cont(200 << 8, 16'h0310, 16'h0380, c_mul, 16'sh1000, 1'b0);
    expect_words(N_WORDS + 16, 1'b0, 1'b0);
    recv = 0;
    reg_write(`GEN_A_CTL, 32'ha);
    wait_words(N_WORDS);
    reg_write(`GEN_A_CTL, 32'h4);
    drain(1'b0);
    end_test(2, "continuous stream");

    // 3 credits held back and then released
    while (pending != 0) begin
      @(negedge bus);
    end
    hold = 1'b1;
    start_cont(156 << 8, 0, 16'h0155, 16'sh2000, -16'sh0200, 1'b1);
    expect_words(N_WORDS + 16, 1'b1, 1'b0);
    recv = 0;
    reg_write(`GEN_A_CTL, 32'ha);
    repeat (30) @(negedge bus);
    check_val("uncredited words", `GEN_CREDITS, pending);
    check_val("words while stalled", `GEN_CREDITS, recv);
    hold = 1'b0;
    wait_words(N_WORDS);
    reg_write(`GEN_A_CTL, 32'h4);
    drain(1'b0);
    end_test(3, "back-pressure");

    // 4 bursts started from masked event line 1
    rng = xorshift(rng);
    start_cont(200 << 8, 16'h0400, 16'h2a80, 16'sh3000 | rng[11:0], 16'sh0000, 1'b1);
    reg_write(`GEN_A_BMODE, 32'h1);
    reg_write(`GEN_A_BDL, 32'd6);
    reg_write(`GEN_A_BLN, 32'd3);
    reg_write(`GEN_A_BNM, 32'd3);
    reg_write(`GEN_A_MSK_STR, 32'h2);
    recv = 0;
    pulse_evn(4'b0100);
    reg_check(`GEN_A_CTL, 32'd0, "ctl status after unmasked event");
    pulse_evn(4'b0010);
    reg_check(`GEN_A_CTL, 32'd2, "ctl status after masked start");
    repeat (10) @(negedge bus);
    check_val("words before trigger", 0, recv);
    expect_bursts();
    reg_write(`GEN_A_CTL, 32'h8);
    wait_words(24);
    drain(1'b1);
    reg_check(`GEN_A_BCNT, 32'd3, "burst count");
    reg_write(`GEN_A_MSK_STR, 32'd0);
    end_test(4, "burst mode");

    // 5 interrupt status, enables and write-one-to-clear
    reg_write(`GEN_A_IRQ_STS, 32'hf);
    reg_write(`GEN_A_IRQ_ENA, 32'd0);
    reg_check(`GEN_A_IRQ_STS, 32'd0, "irq_sts cleared");
    reg_write(`GEN_A_CTL, 32'h2);
    reg_check(`GEN_A_IRQ_STS, 32'h1, "irq_sts after start");
    check_val("irq", 0, int'(irq));
    reg_write(`GEN_A_IRQ_ENA, 32'hf);
    repeat (2) @(negedge bus);
    check_val("irq", 1, int'(irq));
    expect_bursts();
    recv = 0;
    reg_write(`GEN_A_CTL, 32'h8);
    wait_words(24);
    drain(1'b1);
    reg_check(`GEN_A_IRQ_STS, 32'hd, "irq_sts after trigger and last");
    reg_write(`GEN_A_CTL, 32'h4);
    reg_check(`GEN_A_IRQ_STS, 32'hf, "irq_sts after stop");
    reg_write(`GEN_A_IRQ_STS, 32'hf);
    reg_check(`GEN_A_IRQ_STS, 32'd0, "irq_sts after clear");
    repeat (2) @(negedge bus);
    check_val("irq", 0, int'(irq));
    end_test(5, "interrupts");

    $display("summary: 5 tests, %0d failed checks", errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire
